// File: dcache_top.f
+incdir+source
source/dcache_pkg.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_lru.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/tb_clock_gen.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= dcache_top.f
OBJ_DIR ?= obj_dir
FLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam logic [63:0] FILL_XOR = 64'h3c5a_96e1_0f87_d24b;
    localparam int N_RANDOM = 60;
    localparam int N_ACCESS = 12 + N_RANDOM + 12;
    localparam int CYCLE_LIMIT = 40 * N_ACCESS + 10;

    logic  clk;
    logic  rst;
    logic  rd;
    logic  wr;
    addr_t addr;
    word_t wdata;
    mask_t mask;
    word_t rdata;
    logic  finish;
    logic  mem_rd;
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ok;

    int    err_count;
    int    test_count;
    int    bad_tests;
    int    cycles;
    word_t shadow [addr_t];
    logic  ev_wr [$];
    addr_t ev_addr [$];
    word_t ev_data [$];
    addr_t touched [$];

    tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk_o(clk));

    dcache_mem_model #(.FILL_XOR(FILL_XOR)) u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_i    (mem_rd),
        .mem_wr_i    (mem_wr),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_ok_o    (mem_ok)
    );

    dcache_top DUT (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd),
        .wr_i        (wr),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .mask_i      (mask),
        .rdata_o     (rdata),
        .finish_o    (finish),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ok_i    (mem_ok)
    );

    // untouched words follow the memory's fill pattern
    function automatic word_t shadow_read(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_XOR;
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t i);
        return {t, i, 3'b000};
    endfunction

    assert property (@(posedge clk) disable iff (!rst) !(mem_rd && mem_wr))
        else begin
            $display("error at %0t: memory read and write raised together", $time);
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst) finish |-> !(mem_rd || mem_wr))
        else begin
            $display("error at %0t: finish_o raised while memory is busy", $time);
            err_count++;
        end

    // log each completed memory transfer
    always @(negedge clk) begin
        if (rst && mem_ok) begin
            ev_wr.push_back(mem_wr);
            ev_addr.push_back(mem_addr);
            if (mem_wr) begin
                ev_data.push_back(mem_wdata);
                assert (mem_wdata === shadow_read(mem_addr)) else begin
                    $display("MISMATCH t=%0t mem_wdata_o got %h expected %h",
                             $time, mem_wdata, shadow_read(mem_addr));
                    err_count++;
                end
            end else begin
                ev_data.push_back(mem_rdata);
                assert (mem_rdata === shadow_read(mem_addr)) else begin
                    $display("MISMATCH t=%0t mem_rdata_i got %h expected %h",
                             $time, mem_rdata, shadow_read(mem_addr));
                    err_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_event(int k, logic is_wr, addr_t a);
        if (k >= ev_wr.size()) begin
            $display("error at %0t: memory transfer %0d never happened", $time, k);
            err_count++;
        end else begin
            check_value("mem_wr_o", 64'(ev_wr[k]), 64'(is_wr));
            check_value("mem_addr_o", ev_addr[k], a);
        end
    endtask

    // latency counts cycles from the edge that samples the request
    task automatic do_access(input logic is_wr, input addr_t a, input word_t d,
                             input mask_t m, output word_t got, output int lat);
        int n;
        word_t old;
        n = 0;
        @(posedge clk);
        rd <= !is_wr;
        wr <= is_wr;
        addr <= a;
        wdata <= d;
        mask <= m;
        ev_wr.delete();
        ev_addr.delete();
        ev_data.delete();
        do begin
            @(negedge clk);
            n++;
        end while (!finish);
        got = rdata;
        lat = n - 1;
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        if (is_wr) begin
            old = shadow_read(a);
            for (int b = 0; b < 8; b++) begin
                if (m[b]) begin
                    old[8*b +: 8] = d[8*b +: 8];
                end
            end
            shadow[a] = old;
        end
    endtask

    task automatic load_check(input addr_t a, output int lat);
        word_t got;
        do_access(1'b0, a, '0, '0, got, lat);
        check_value("rdata_o", got, shadow_read(a));
    endtask

    task automatic store_word(input addr_t a, input word_t d, input mask_t m, output int lat);
        word_t got;
        do_access(1'b1, a, d, m, got, lat);
    endtask

    task automatic end_test(string name, int err_before);
        test_count++;
        if (err_count == err_before) begin
            $display("test %s: ok", name);
        end else begin
            bad_tests++;
            $display("test %s: %0d errors", name, err_count - err_before);
        end
    endtask

    initial begin
        int    e0;
        int    lat;
        int    dup;
        addr_t a0;
        addr_t a1;
        addr_t a2;
        addr_t a3;
        addr_t a4;
        addr_t ra;
        tag_t  tags [4];
        tag_t  tbase;
        index_t idxs [3];

        rst = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        wdata = '0;
        mask = '0;
        err_count = 0;
        test_count = 0;
        bad_tests = 0;
        cycles = 0;
        e0 = $urandom(32'hb9e7);

        repeat (2) @(posedge clk);
        rst <= 1'b1;

        // quiet outputs after reset
        e0 = err_count;
        repeat (3) begin
            @(negedge clk);
            check_value("finish_o", 64'(finish), 64'h0);
            check_value("mem_rd_o", 64'(mem_rd), 64'h0);
            check_value("mem_wr_o", 64'(mem_wr), 64'h0);
        end
        end_test("reset", e0);

        e0 = err_count;
        a0 = make_addr(55'h1234, 6'd1);
        load_check(a0, lat);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd1);
        check_event(0, 1'b0, a0);
        end_test("cold load", e0);

        e0 = err_count;
        load_check(a0, lat);
        check_value("hit latency", 64'(lat), 64'd2);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd0);
        store_word(a0, 64'h1122_3344_5566_7788, 8'h0f, lat);
        check_value("hit latency", 64'(lat), 64'd2);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd0);
        load_check(a0, lat);
        check_value("hit latency", 64'(lat), 64'd2);
        end_test("hit and merge", e0);

        // set 5 fills way 0 then way 1, way 0 is dirty
        e0 = err_count;
        a1 = make_addr(55'h2_0000, 6'd5);
        a2 = make_addr(55'h2_0001, 6'd5);
        a3 = make_addr(55'h2_0002, 6'd5);
        a4 = make_addr(55'h2_0003, 6'd5);
        store_word(a1, 64'hdead_beef_0123_4567, 8'hff, lat);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd1);
        check_event(0, 1'b0, a1);
        load_check(a2, lat);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd1);
        check_event(0, 1'b0, a2);
        load_check(a3, lat);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd2);
        check_event(0, 1'b1, a1);
        if (ev_data.size() > 0) begin
            check_value("writeback data", ev_data[0], shadow_read(a1));
        end
        check_event(1, 1'b0, a3);
        // clean victim now
        load_check(a4, lat);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd1);
        check_event(0, 1'b0, a4);
        // a4 replaced the older a2, so a3 stays resident
        load_check(a3, lat);
        check_value("hit latency", 64'(lat), 64'd2);
        check_value("mem transfers", 64'(ev_wr.size()), 64'd0);
        load_check(a1, lat);
        end_test("eviction", e0);

        e0 = err_count;
        tbase = 55'({$urandom, $urandom});
        for (int k = 0; k < 4; k++) begin
            tags[k] = {tbase[54:2], 2'(k)};
        end
        idxs[0] = 6'd7;
        idxs[1] = 6'd20;
        idxs[2] = 6'd41;
        for (int i = 0; i < N_RANDOM; i++) begin
            ra = make_addr(tags[$urandom_range(3, 0)], idxs[$urandom_range(2, 0)]);
            dup = 0;
            foreach (touched[j]) begin
                if (touched[j] == ra) begin
                    dup = 1;
                end
            end
            if (dup == 0) begin
                touched.push_back(ra);
            end
            if ($urandom_range(1, 0) == 1) begin
                store_word(ra, {$urandom, $urandom}, 8'($urandom_range(255, 0)), lat);
            end else begin
                load_check(ra, lat);
            end
        end
        foreach (touched[j]) begin
            load_check(touched[j], lat);
        end
        end_test("random mix", e0);

        $display("tests %0d, tests with errors %0d, failed checks %0d",
                 test_count, bad_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/dcache_mem_model.sv
`timescale 1ns/1ns

module dcache_mem_model #(
    parameter logic [63:0] FILL_XOR = 64'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_rd_i,
    input  logic              mem_wr_i,
    input  dcache_pkg::addr_t mem_addr_i,
    input  dcache_pkg::word_t mem_wdata_i,
    output dcache_pkg::word_t mem_rdata_o,
    output logic              mem_ok_o
);
    import dcache_pkg::*;

    // sparse storage, only written words are kept
    word_t store_q [addr_t];
    int unsigned delay;

    function automatic word_t read_word(addr_t a);
        if (store_q.exists(a)) begin
            return store_q[a];
        end
        return a ^ FILL_XOR;
    endfunction

    initial begin
        mem_ok_o = 1'b0;
        mem_rdata_o = '0;
        wait (rst === 1'b1);
        forever begin
            @(negedge clk);
            if (mem_rd_i || mem_wr_i) begin
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clk);
                if (mem_wr_i) begin
                    store_q[mem_addr_i] = mem_wdata_i;
                end else begin
                    mem_rdata_o <= read_word(mem_addr_i);
                end
                mem_ok_o <= 1'b1;
                // one cycle strobe
                @(posedge clk);
                mem_ok_o <= 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_i,
    input  logic              wr_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::mask_t mask_i,
    output dcache_pkg::word_t rdata_o,
    output logic              finish_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::word_t mem_wdata_o,
    input  dcache_pkg::word_t mem_rdata_i,
    input  logic              mem_ok_i
);
    import dcache_pkg::*;

    index_t   arr_index;
    way_vec_t arr_we;
    tag_t     arr_tag;
    logic     dirty_set;
    mask_t    data_mask;
    word_t    data_wdata;
    way_vec_t hit;
    way_vec_t valid;
    way_vec_t dirty;
    tag_t     tag0;
    tag_t     tag1;
    word_t    rdata0;
    word_t    rdata1;
    logic     lru_update;
    way_t     used_way;
    way_t     victim;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rd_i         (rd_i),
        .wr_i         (wr_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .mask_i       (mask_i),
        .rdata_o      (rdata_o),
        .finish_o     (finish_o),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ok_i     (mem_ok_i),
        .arr_index_o  (arr_index),
        .arr_we_o     (arr_we),
        .arr_tag_o    (arr_tag),
        .dirty_set_o  (dirty_set),
        .data_mask_o  (data_mask),
        .data_wdata_o (data_wdata),
        .hit_i        (hit),
        .valid_i      (valid),
        .dirty_i      (dirty),
        .tag0_i       (tag0),
        .tag1_i       (tag1),
        .rdata0_i     (rdata0),
        .rdata1_i     (rdata1),
        .lru_update_o (lru_update),
        .used_way_o   (used_way),
        .victim_i     (victim)
    );

    // request tag is both the write tag and the compare tag
    dcache_tag_array u_tag (
        .clk         (clk),
        .rst         (rst),
        .index_i     (arr_index),
        .we_i        (arr_we),
        .tag_i       (arr_tag),
        .dirty_set_i (dirty_set),
        .cmp_tag_i   (arr_tag),
        .hit_o       (hit),
        .valid_o     (valid),
        .dirty_o     (dirty),
        .tag0_o      (tag0),
        .tag1_o      (tag1)
    );

    dcache_data_array u_data (
        .clk      (clk),
        .index_i  (arr_index),
        .we_i     (arr_we),
        .mask_i   (data_mask),
        .wdata_i  (data_wdata),
        .rdata0_o (rdata0),
        .rdata1_o (rdata1)
    );

    dcache_lru u_lru (
        .clk        (clk),
        .rst        (rst),
        .index_i    (arr_index),
        .update_i   (lru_update),
        .used_way_i (used_way),
        .victim_o   (victim)
    );

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    // core side
    input  logic                 rd_i,
    input  logic                 wr_i,
    input  dcache_pkg::addr_t    addr_i,
    input  dcache_pkg::word_t    wdata_i,
    input  dcache_pkg::mask_t    mask_i,
    output dcache_pkg::word_t    rdata_o,
    output logic                 finish_o,
    // memory side
    output logic                 mem_rd_o,
    output logic                 mem_wr_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::word_t    mem_wdata_o,
    input  dcache_pkg::word_t    mem_rdata_i,
    input  logic                 mem_ok_i,
    // arrays
    output dcache_pkg::index_t   arr_index_o,
    output dcache_pkg::way_vec_t arr_we_o,
    output dcache_pkg::tag_t     arr_tag_o,
    output logic                 dirty_set_o,
    output dcache_pkg::mask_t    data_mask_o,
    output dcache_pkg::word_t    data_wdata_o,
    input  dcache_pkg::way_vec_t hit_i,
    input  dcache_pkg::way_vec_t valid_i,
    input  dcache_pkg::way_vec_t dirty_i,
    input  dcache_pkg::tag_t     tag0_i,
    input  dcache_pkg::tag_t     tag1_i,
    input  dcache_pkg::word_t    rdata0_i,
    input  dcache_pkg::word_t    rdata1_i,
    // lru
    output logic                 lru_update_o,
    output dcache_pkg::way_t     used_way_o,
    input  dcache_pkg::way_t     victim_i
);
    import dcache_pkg::*;

    cache_state_t state_q;
    cache_state_t state_d;
    way_t         way_q;
    word_t        data_q;
    tag_t         wb_tag_q;
    index_t       index;
    way_t         fill_way;
    way_t         lookup_way;
    logic         need_wb;
    logic         done;
    way_vec_t     way_sel;

    assign index = addr_i[`DCACHE_INDEX_MSB:`DCACHE_INDEX_LSB];
    assign arr_index_o = index;
    assign arr_tag_o = addr_i[63:`DCACHE_TAG_LSB];

    // first invalid way, else the lru victim
    assign fill_way = !valid_i[0] ? 1'b0 : (!valid_i[1] ? 1'b1 : victim_i);
    assign lookup_way = (|hit_i) ? hit_i[1] : fill_way;
    assign need_wb = valid_i[fill_way] & dirty_i[fill_way];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rd_i || wr_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (|hit_i) begin
                    state_d = HIT;
                end else if (need_wb) begin
                    state_d = WBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WBACK: begin
                if (mem_ok_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ok_i) begin
                    state_d = MERGE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            way_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) begin
                way_q <= lookup_way;
            end
        end
    end

    // hit word or victim word, later replaced by the refill
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            data_q <= lookup_way ? rdata1_i : rdata0_i;
            wb_tag_q <= fill_way ? tag1_i : tag0_i;
        end else if (state_q == REFILL && mem_ok_i) begin
            data_q <= mem_rdata_i;
        end
    end

    assign mem_rd_o = (state_q == REFILL);
    assign mem_wr_o = (state_q == WBACK);
    // victim address during write-back
    assign mem_addr_o = (state_q == WBACK) ?
                        {wb_tag_q, index, {`DCACHE_INDEX_LSB{1'b0}}} :
                        {addr_i[63:`DCACHE_INDEX_LSB], {`DCACHE_INDEX_LSB{1'b0}}};
    assign mem_wdata_o = data_q;

    assign way_sel = {way_q, ~way_q};

    always_comb begin
        arr_we_o = '0;
        if ((state_q == HIT || state_q == MERGE) && wr_i) begin
            arr_we_o = way_sel;
        end else if (state_q == REFILL && mem_ok_i) begin
            arr_we_o = way_sel;
        end
    end

    // refill lands clean with all bytes, a store merges under its mask
    assign dirty_set_o = (state_q != REFILL);
    assign data_mask_o = (state_q == REFILL) ? '1 : mask_i;
    assign data_wdata_o = (state_q == REFILL) ? mem_rdata_i : wdata_i;

    assign done = (state_q == HIT) || (state_q == MERGE);
    assign finish_o = done;
    assign rdata_o = data_q;
    assign lru_update_o = done;
    assign used_way_o = way_q;

endmodule

// File: source/dcache_lru.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_lru (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index_i,
    input  logic               update_i,
    input  dcache_pkg::way_t   used_way_i,
    output dcache_pkg::way_t   victim_o
);

    // one bit per set, names the older way
    logic [`DCACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lru_q <= '0;
        end else if (update_i) begin
            lru_q[index_i] <= ~used_way_i;
        end
    end

    assign victim_o = lru_q[index_i];

endmodule

// File: source/dcache_data_array.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   index_i,
    input  dcache_pkg::way_vec_t we_i,
    input  dcache_pkg::mask_t    mask_i,
    input  dcache_pkg::word_t    wdata_i,
    output dcache_pkg::word_t    rdata0_o,
    output dcache_pkg::word_t    rdata1_o
);
    import dcache_pkg::*;

    word_t data_mem [`DCACHE_WAYS][`DCACHE_SETS];
    word_t data_rd [`DCACHE_WAYS];

    // both ways read every cycle, writes per byte lane
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            data_rd[w] <= data_mem[w][index_i];
            if (we_i[w]) begin
                for (int b = 0; b < `DCACHE_WORD_BYTES; b++) begin
                    if (mask_i[b]) begin
                        data_mem[w][index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    assign rdata0_o = data_rd[0];
    assign rdata1_o = data_rd[1];

endmodule

// File: source/dcache_tag_array.sv
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::index_t   index_i,
    input  dcache_pkg::way_vec_t we_i,
    input  dcache_pkg::tag_t     tag_i,
    input  logic                 dirty_set_i,
    input  dcache_pkg::tag_t     cmp_tag_i,
    output dcache_pkg::way_vec_t hit_o,
    output dcache_pkg::way_vec_t valid_o,
    output dcache_pkg::way_vec_t dirty_o,
    output dcache_pkg::tag_t     tag0_o,
    output dcache_pkg::tag_t     tag1_o
);
    import dcache_pkg::*;

    logic [`DCACHE_SETS-1:0] valid_q [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] dirty_q [`DCACHE_WAYS];
    tag_t tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
    tag_t tag_rd [`DCACHE_WAYS];

    // status bits, cleared on reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            valid_o <= '0;
            dirty_o <= '0;
        end else begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_o[w] <= valid_q[w][index_i];
                dirty_o[w] <= dirty_q[w][index_i];
                if (we_i[w]) begin
                    valid_q[w][index_i] <= 1'b1;
                    dirty_q[w][index_i] <= dirty_set_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            tag_rd[w] <= tag_mem[w][index_i];
            if (we_i[w]) begin
                tag_mem[w][index_i] <= tag_i;
            end
        end
    end

    // compare on the registered read
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_o[w] = valid_o[w] && (tag_rd[w] == cmp_tag_i);
        end
    end

    assign tag0_o = tag_rd[0];
    assign tag1_o = tag_rd[1];

endmodule

// File: source/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [8*`DCACHE_WORD_BYTES-1:0] word_t;
    typedef logic [`DCACHE_WORD_BYTES-1:0] mask_t;
    typedef logic [`DCACHE_INDEX_MSB-`DCACHE_INDEX_LSB:0] index_t;
    typedef logic [63-`DCACHE_TAG_LSB:0] tag_t;
    typedef logic way_t;
    typedef logic [`DCACHE_WAYS-1:0] way_vec_t;

    // single controller for loads and stores
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WBACK,
        REFILL,
        MERGE
    } cache_state_t;

endpackage

// File: source/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DCACHE_SETS 64
`define DCACHE_WAYS 2

// address split, byte offset below the index
`define DCACHE_INDEX_LSB 3
`define DCACHE_INDEX_MSB 8
`define DCACHE_TAG_LSB 9

// one 64-bit word per line
`define DCACHE_WORD_BYTES 8

`endif
